// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= drum_mixer_tb
RTL_TOP    ?= drum_mixer_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/drum_mixer_tb.sv
module drum_mixer_tb import drum_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS      = 2**ADDR_WIDTH;
  localparam int SAMPLE_MAX = 32767;
  localparam int SAMPLE_MIN = -32768;
  // idle drain plus four drains of a full sample and a FIFO of leftovers
  localparam int NUM_FRAMES = FIFO_DEPTH * 2 + 4 + 4 * (SAMPLE_LEN + FIFO_DEPTH);
  // IDLE, START, PUSH and per voice a request pair with up to three stolen cycles
  localparam int FRAME_CYCLES   = 3 + NUM_PADS * 5;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES * 2;

  logic      clk;
  logic      rst;
  pad_mask_t drumpads_raw;
  logic      wr_en;
  mem_addr_t wr_addr;
  sample_t   wr_data;
  logic      priority_rd_en;
  mem_addr_t priority_addr;
  sample_t   priority_rd_data;
  logic      fifo_rd_en;
  sample_t   fifo_data;
  logic      fifo_empty;

  integer    seed;
  int        cycle_cnt;
  int        pop_count;
  int        pops_wanted;
  int        error_count;
  int        trig_pulses;
  logic      steal_done;
  sample_t   mem_model [WORDS];
  // one entry per voice start, frame index and voice
  int        trig_frame [$];
  int        trig_voice [$];

  drum_mixer_top dut0 (
    .clk             (clk),
    .rst             (rst),
    .drumpads_raw    (drumpads_raw),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .priority_rd_en  (priority_rd_en),
    .priority_addr   (priority_addr),
    .priority_rd_data(priority_rd_data),
    .fifo_rd_en      (fifo_rd_en),
    .fifo_data       (fifo_data),
    .fifo_empty      (fifo_empty)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // expected mix of frame n from the memory copy and the trigger list
  function automatic sample_t expected_frame(int n);
    int        sum;
    int        start;
    mem_addr_t idx;
    sum = 0;
    for (int v = 0; v < NUM_PADS; v++) begin
      start = -1;
      // a later trigger of the same voice restarts it
      for (int i = 0; i < trig_frame.size(); i++) begin
        if (trig_voice[i] == v && trig_frame[i] <= n && trig_frame[i] > start) begin
          start = trig_frame[i];
        end
      end
      if (start >= 0 && n - start < SAMPLE_LEN) begin
        idx = mem_addr_t'(v * SAMPLE_LEN + n - start);
        sum += int'(mem_model[idx]);
      end
    end
    if (sum > SAMPLE_MAX) begin
      sum = SAMPLE_MAX;
    end else if (sum < SAMPLE_MIN) begin
      sum = SAMPLE_MIN;
    end
    return sample_t'(sum);
  endfunction

  // positive words near full scale, so two voices already clip
  function automatic sample_t large_word();
    logic [31:0] rnd;
    rnd = $random(seed);
    return {4'h5, rnd[11:0]};
  endfunction

  task automatic fail_run(string msg);
    error_count++;
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_word(mem_addr_t addr, sample_t data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    mem_model[addr] = data;
    next_cycle();
    wr_en = 1'b0;
  endtask

  task automatic check_read(mem_addr_t addr);
    assert (priority_rd_data == mem_model[addr]) else
      fail_run($sformatf("Error at %0t: priority read of %0d gave %0d, expected %0d",
                         $time, addr, priority_rd_data, mem_model[addr]));
  endtask

  task automatic hold_pads(pad_mask_t mask, int cycles);
    drumpads_raw = mask;
    repeat (cycles) next_cycle();
  endtask

  // only called while the FIFO is full, so the frame index is known
  task automatic press_pads(pad_mask_t mask, bit bounce);
    int pulses_before;
    pulses_before = trig_pulses;
    for (int v = 0; v < NUM_PADS; v++) begin
      if (mask[v]) begin
        trig_frame.push_back(pop_count + FIFO_DEPTH);
        trig_voice.push_back(v);
      end
    end
    if (bounce) begin
      hold_pads(mask, DEBOUNCE_CYCLES / 2);
      hold_pads('0, 1);
    end
    hold_pads(mask, DEBOUNCE_CYCLES + 8);
    hold_pads('0, DEBOUNCE_CYCLES + 8);
    // one pulse per pressed pad, however much it bounced
    assert (trig_pulses - pulses_before == $countones(mask)) else
      fail_run($sformatf("Error at %0t: %0d trigger pulses for pads %b, expected %0d",
                         $time, trig_pulses - pulses_before, mask, $countones(mask)));
  endtask

  task automatic wait_fifo_full();
    do begin
      next_cycle();
    end while (!dut0.fifo_full);
  endtask

  task automatic drain_frames(int n);
    pops_wanted = n;
    wait (pops_wanted == 0);
  endtask

  // random priority reads, each checked one cycle later
  task automatic steal_reads();
    logic [31:0] rnd;
    logic        was_read;
    mem_addr_t   addr;
    was_read = 1'b0;
    addr     = '0;
    while (!steal_done) begin
      next_cycle();
      if (was_read) begin
        check_read(addr);
      end
      rnd            = $random(seed);
      was_read       = rnd[0];
      addr           = rnd[ADDR_WIDTH:1];
      priority_rd_en = was_read;
      priority_addr  = addr;
    end
    priority_rd_en = 1'b0;
  endtask

  // trigger pulses seen inside the DUT
  initial begin : count_triggers
    trig_pulses = 0;
    forever begin
      next_cycle();
      trig_pulses += $countones(dut0.pads_trigger);
    end
  end

  initial begin : compare_frames
    sample_t want;
    fifo_rd_en = 1'b0;
    forever begin
      next_cycle();
      if (pops_wanted > 0 && !fifo_empty) begin
        want = expected_frame(pop_count);
        assert (fifo_data == want) else
          fail_run($sformatf("Error at %0t: frame %0d mixed %0d, expected %0d",
                             $time, pop_count, fifo_data, want));
        fifo_rd_en = 1'b1;
        pop_count++;
        pops_wanted--;
      end else begin
        fifo_rd_en = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        fail_run($sformatf("run timed out after %0d cycles", cycle_cnt));
      end
    end
  end

  initial begin : run_tests
    seed           = 20;
    rst            = 1'b1;
    drumpads_raw   = '0;
    wr_en          = 1'b0;
    wr_addr        = '0;
    wr_data        = '0;
    priority_rd_en = 1'b0;
    priority_addr  = '0;
    error_count    = 0;
    pop_count      = 0;
    pops_wanted    = 0;
    steal_done     = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // FIFO starts out empty
    assert (fifo_empty) else
      fail_run($sformatf("Error at %0t: FIFO not empty after reset", $time));

    // load every word, then read all back on the priority port
    for (int a = 0; a < WORDS; a++) begin
      write_word(mem_addr_t'(a), sample_t'($random(seed)));
    end
    for (int a = 0; a < WORDS; a++) begin
      priority_rd_en = 1'b1;
      priority_addr  = mem_addr_t'(a);
      next_cycle();
      check_read(mem_addr_t'(a));
    end
    priority_rd_en = 1'b0;

    // no pads, so only zeros
    wait_fifo_full();
    drain_frames(FIFO_DEPTH + 4);

    // clean press of pad 2
    wait_fifo_full();
    press_pads(4'b0100, 1'b0);
    drain_frames(SAMPLE_LEN + FIFO_DEPTH);

    // short glitches on pad 0, then a bouncy press of pad 1
    wait_fifo_full();
    repeat (3) begin
      hold_pads(4'b0001, DEBOUNCE_CYCLES - 4);
      hold_pads('0, 4);
    end
    press_pads(4'b0010, 1'b1);
    drain_frames(SAMPLE_LEN + FIFO_DEPTH);

    // overlapping loud voices and a retrigger of voice 0
    wait_fifo_full();
    for (int a = 0; a < WORDS; a++) begin
      write_word(mem_addr_t'(a), large_word());
    end
    press_pads(4'b0011, 1'b0);
    drain_frames(3);
    wait_fifo_full();
    press_pads(4'b1100, 1'b0);
    drain_frames(5);
    wait_fifo_full();
    press_pads(4'b0001, 1'b0);
    drain_frames(SAMPLE_LEN + FIFO_DEPTH);

    // all voices while the priority port steals cycles
    wait_fifo_full();
    press_pads('1, 1'b0);
    fork
      begin
        drain_frames(SAMPLE_LEN + FIFO_DEPTH);
        steal_done = 1'b1;
      end
      steal_reads();
    join

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: logic/drum_mixer_top.sv
module drum_mixer_top import drum_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  pad_mask_t drumpads_raw,
  input  logic      wr_en,
  input  mem_addr_t wr_addr,
  input  sample_t   wr_data,
  input  logic      priority_rd_en,
  input  mem_addr_t priority_addr,
  output sample_t   priority_rd_data,
  input  logic      fifo_rd_en,
  output sample_t   fifo_data,
  output logic      fifo_empty
);

  pad_mask_t pads_trigger;
  logic      acc_clear;
  logic      acc_add;
  sample_t   mix_out;
  logic      fifo_push;
  logic      fifo_full;

  // mixer read port into the sample memory
  mem_rd_if rd_if ();

  // accepted pad levels have no reader in this design
  drumpad_conditioner pad_cond (
    .clk         (clk),
    .rst         (rst),
    .pads_raw    (drumpads_raw),
    .pads_level  (),
    .pads_trigger(pads_trigger)
  );

  mixer_sequencer mix_seq (
    .clk         (clk),
    .rst         (rst),
    .pads_trigger(pads_trigger),
    .rd          (rd_if.sequencer),
    .acc_clear   (acc_clear),
    .acc_add     (acc_add),
    .fifo_full   (fifo_full),
    .fifo_push   (fifo_push)
  );

  sample_memory sample_mem (
    .clk             (clk),
    .rst             (rst),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .priority_rd_en  (priority_rd_en),
    .priority_addr   (priority_addr),
    .priority_rd_data(priority_rd_data),
    .rd              (rd_if.memory)
  );

  // words come straight off the mixer read port
  mix_accumulator accumulator (
    .clk    (clk),
    .rst    (rst),
    .clear  (acc_clear),
    .add    (acc_add),
    .sample (rd_if.rd_data),
    .mix_out(mix_out)
  );

  // codec side drains through fifo_rd_en
  sample_fifo out_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (fifo_push),
    .push_data(mix_out),
    .pop      (fifo_rd_en),
    .pop_data (fifo_data),
    .full     (fifo_full),
    .empty    (fifo_empty)
  );

endmodule

// File: logic/drum_pkg.sv
package drum_pkg;

  // pads and voices are one to one
  localparam int NUM_PADS        = 4;
  localparam int SAMPLE_LEN      = 16;
  // four regions of SAMPLE_LEN words
  localparam int ADDR_WIDTH      = 6;
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int FIFO_DEPTH      = 8;

  typedef logic signed [15:0] sample_t;
  // two guard bits so four full-scale samples cannot wrap
  typedef logic signed [17:0] mix_sum_t;
  typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [3:0] voice_pos_t;
  typedef logic [NUM_PADS-1:0] pad_mask_t;

  typedef enum logic [2:0] {
    IDLE,
    START,
    REQUEST,
    WAIT,
    PUSH
  } mixer_state_t;

endpackage

// File: logic/drumpad_conditioner.sv
module drumpad_conditioner import drum_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  pad_mask_t pads_raw,
  output pad_mask_t pads_level,
  output pad_mask_t pads_trigger
);

  typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] deb_cnt_t;

  // pads are asynchronous to clk
  pad_mask_t sync_q1;
  pad_mask_t sync_q2;

  // cycles in a row each pad has differed from its accepted level
  deb_cnt_t  stable_cnt [NUM_PADS];

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pads_raw;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pads_level   <= '0;
      pads_trigger <= '0;
      for (int i = 0; i < NUM_PADS; i++) begin
        stable_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_PADS; i++) begin
        pads_trigger[i] <= 1'b0;
        if (sync_q2[i] == pads_level[i]) begin
          // any bounce back restarts the window
          stable_cnt[i] <= '0;
        end else if (stable_cnt[i] == deb_cnt_t'(DEBOUNCE_CYCLES - 1)) begin
          stable_cnt[i]   <= '0;
          pads_level[i]   <= sync_q2[i];
          // pulse only on the press, not the release
          pads_trigger[i] <= sync_q2[i];
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/mem_rd_if.sv
interface mem_rd_if import drum_pkg::*; ();

  mem_addr_t addr;
  logic      rd_en;
  sample_t   rd_data;
  logic      rd_valid;

  // request side holds addr and rd_en until rd_valid
  modport sequencer (
    output addr,
    output rd_en,
    input  rd_valid
  );

  modport memory (
    input  addr,
    input  rd_en,
    output rd_data,
    output rd_valid
  );

endinterface

// File: logic/mix_accumulator.sv
module mix_accumulator import drum_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    clear,
  input  logic    add,
  input  sample_t sample,
  output sample_t mix_out
);

  mix_sum_t sum;
  // sign bit of the sample range plus the guard bits
  logic [$bits(mix_sum_t)-$bits(sample_t):0] sign_bits;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      sum <= '0;
    end else if (add) begin
      sum <= sum + mix_sum_t'(sample);
    end
  end

  assign sign_bits = sum[$bits(mix_sum_t)-1:$bits(sample_t)-1];

  // clip to the sample range
  always_comb begin
    if (sign_bits == '0 || sign_bits == '1) begin
      mix_out = sample_t'(sum);
    end else if (!sum[$bits(mix_sum_t)-1]) begin
      mix_out = {1'b0, {($bits(sample_t) - 1){1'b1}}};
    end else begin
      mix_out = {1'b1, {($bits(sample_t) - 1){1'b0}}};
    end
  end

endmodule

// File: logic/mixer_sequencer.sv
module mixer_sequencer import drum_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  pad_mask_t   pads_trigger,
  mem_rd_if.sequencer rd,
  output logic        acc_clear,
  output logic        acc_add,
  input  logic        fifo_full,
  output logic        fifo_push
);

  typedef logic [$clog2(NUM_PADS)-1:0] voice_idx_t;

  mixer_state_t state;
  pad_mask_t    pending;
  pad_mask_t    active;
  voice_pos_t   pos [NUM_PADS];
  voice_idx_t   voice;

  always_comb begin
    acc_clear = (state == START);
    fifo_push = (state == PUSH);
    acc_add   = (state == WAIT) && rd.rd_valid;
    // request stays up through stolen cycles, drops once data is back
    rd.rd_en  = ((state == REQUEST) && active[voice]) ||
                ((state == WAIT) && !rd.rd_valid);
    // voice region base plus current position
    rd.addr   = mem_addr_t'(voice) * mem_addr_t'(SAMPLE_LEN) + mem_addr_t'(pos[voice]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      pending <= '0;
      active  <= '0;
      voice   <= '0;
      for (int i = 0; i < NUM_PADS; i++) begin
        pos[i] <= '0;
      end
    end else begin
      // triggers wait here for the next frame start
      if (state == START) begin
        pending <= pads_trigger;
      end else begin
        pending <= pending | pads_trigger;
      end

      case (state)
        IDLE: begin
          if (!fifo_full) begin
            state <= START;
          end
        end
        START: begin
          active <= active | pending;
          for (int i = 0; i < NUM_PADS; i++) begin
            if (pending[i]) begin
              pos[i] <= '0;
            end
          end
          voice <= '0;
          state <= REQUEST;
        end
        REQUEST: begin
          if (active[voice]) begin
            state <= WAIT;
          end else if (voice == voice_idx_t'(NUM_PADS - 1)) begin
            state <= PUSH;
          end else begin
            voice <= voice + 1'b1;
          end
        end
        WAIT: begin
          if (rd.rd_valid) begin
            if (voice == voice_idx_t'(NUM_PADS - 1)) begin
              state <= PUSH;
            end else begin
              voice <= voice + 1'b1;
              state <= REQUEST;
            end
          end
        end
        PUSH: begin
          for (int i = 0; i < NUM_PADS; i++) begin
            if (active[i]) begin
              pos[i] <= pos[i] + 1'b1;
              // last word just played
              if (pos[i] == voice_pos_t'(SAMPLE_LEN - 1)) begin
                active[i] <= 1'b0;
              end
            end
          end
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: logic/sample_fifo.sv
module sample_fifo import drum_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    push,
  input  sample_t push_data,
  input  logic    pop,
  output sample_t pop_data,
  output logic    full,
  output logic    empty
);

  typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  sample_t   entries [FIFO_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;
  logic      do_push;
  logic      do_pop;

  assign full     = (count == fifo_cnt_t'(FIFO_DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  // head is visible before the pop
  assign pop_data = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      entries[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: logic/sample_memory.sv
module sample_memory import drum_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_en,
  input  mem_addr_t wr_addr,
  input  sample_t   wr_data,
  input  logic      priority_rd_en,
  input  mem_addr_t priority_addr,
  output sample_t   priority_rd_data,
  mem_rd_if.memory  rd
);

  sample_t   mem [2**ADDR_WIDTH];
  sample_t   rd_q;
  mem_addr_t rd_addr;

  // one read per cycle, priority port takes it first
  always_comb begin
    rd_addr = priority_rd_en ? priority_addr : rd.addr;
  end

  // read sees the old word when it hits the write address
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (priority_rd_en || rd.rd_en) begin
      rd_q <= mem[rd_addr];
    end
  end

  // mixer request served only when not stolen
  always_ff @(posedge clk) begin
    if (rst) begin
      rd.rd_valid <= 1'b0;
    end else begin
      rd.rd_valid <= rd.rd_en && !priority_rd_en;
    end
  end

  // both ports share the read register
  assign priority_rd_data = rd_q;
  assign rd.rd_data       = rd_q;

endmodule

// File: src.f
logic/drum_pkg.sv
logic/mem_rd_if.sv
logic/drumpad_conditioner.sv
logic/mixer_sequencer.sv
logic/sample_memory.sv
logic/mix_accumulator.sv
logic/sample_fifo.sv
logic/drum_mixer_top.sv
dv/drum_mixer_tb.sv
